// File: design/soc_bus_defines.svh
`ifndef SOC_BUS_DEFINES_SVH
`define SOC_BUS_DEFINES_SVH

// on-chip RAM, 4 KB of 32-bit words
`define RAM_BASE            32'h8000_0000
`define RAM_WORDS           1024
`define RAM_BYTES           (`RAM_WORDS * 4)

// machine timer
`define MTIMECMP_ADDR       32'h0200_4000
`define MTIME_ADDR          32'h0200_BFF8
`define MTIMECMP_RESET      64'h8000_0000

// interrupt controller, priorities at 4 bytes per id
`define PLIC_BASE           32'h0C00_0000
`define PLIC_NUM_IDS        6
`define PLIC_PENDING        32'h0C00_1000
`define PLIC_ENABLE         32'h0C00_2000
`define PLIC_ENABLE_STRIDE  32'h0000_0080
`define PLIC_THRESHOLD      32'h0C20_0000
`define PLIC_CLAIM          32'h0C20_0004
// threshold and claim share the per-context stride
`define PLIC_CTX_STRIDE     32'h0000_1000

`endif

// File: design/soc_bus_pkg.sv
package soc_bus_pkg;

    typedef logic [31:0] bus_addr_t;
    typedef logic [63:0] bus_data_t;
    typedef logic [31:0] word_t;
    typedef logic [9:0]  ram_index_t;
    typedef logic [2:0]  irq_prio_t;

    // bit 2 marks unsigned loads, bits 1:0 give the size
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_e;

    typedef enum logic [1:0] {
        IDLE,
        BEAT0,
        BEAT1,
        RESP
    } seq_state_e;

endpackage

// File: design/periph_if.sv
`timescale 1ns/1ps

interface periph_if import soc_bus_pkg::*; ();

    // one-cycle strobe from the sequencer
    logic      sel;
    logic      we;
    bus_addr_t addr;
    ls_type_e  ls;
    bus_data_t wdata;
    // valid in the cycle after sel
    bus_data_t rdata;

    modport master (
        output sel,
        output we,
        output addr,
        output ls,
        output wdata,
        input  rdata
    );

    modport slave (
        input  sel,
        input  we,
        input  addr,
        input  ls,
        input  wdata,
        output rdata
    );

endinterface

// File: design/bus_sequencer.sv
`timescale 1ns/1ps
`include "soc_bus_defines.svh"

module bus_sequencer import soc_bus_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      req_valid,
    output logic      req_ready,
    input  bus_addr_t req_addr,
    input  logic      req_write,
    input  ls_type_e  req_ls,
    input  bus_data_t req_wdata,
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output bus_data_t rsp_rdata,
    output logic      rsp_err,
    periph_if.master  ram,
    periph_if.master  tmr,
    periph_if.master  plic
);

    seq_state_e state;
    logic       accept;
    logic       dec_ram;
    logic       dec_tmr;
    logic       dec_plic;
    logic       bad_align;
    logic       bad_req;
    logic       hit_ram_q;
    logic       hit_tmr_q;
    logic       hit_plic_q;
    logic       we_q;
    logic       dbl_q;
    bus_addr_t  addr_q;
    ls_type_e   ls_q;
    bus_data_t  wdata_q;
    bus_addr_t  beat_addr;
    bus_data_t  beat_wdata;
    bus_data_t  beat_rdata;

    assign req_ready = (state == IDLE);
    assign accept    = req_valid && req_ready;

    // address map decode
    assign dec_ram  = req_addr >= `RAM_BASE && req_addr < `RAM_BASE + `RAM_BYTES;
    assign dec_tmr  = req_addr == `MTIME_ADDR || req_addr == `MTIMECMP_ADDR;
    assign dec_plic = (req_addr >= `PLIC_BASE && req_addr < `PLIC_BASE + 4 * `PLIC_NUM_IDS)
        || req_addr == `PLIC_PENDING
        || req_addr == `PLIC_ENABLE
        || req_addr == `PLIC_ENABLE + `PLIC_ENABLE_STRIDE
        || req_addr == `PLIC_THRESHOLD
        || req_addr == `PLIC_THRESHOLD + `PLIC_CTX_STRIDE
        || req_addr == `PLIC_CLAIM
        || req_addr == `PLIC_CLAIM + `PLIC_CTX_STRIDE;

    // natural alignment, 3'b111 is not a legal code
    always_comb begin
        case (req_ls[1:0])
            2'b01:   bad_align = req_addr[0];
            2'b10:   bad_align = |req_addr[1:0];
            2'b11:   bad_align = |req_addr[2:0] || req_ls[2];
            default: bad_align = 1'b0;
        endcase
    end

    assign bad_req = bad_align || !(dec_ram || dec_tmr || dec_plic);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= IDLE;
            rsp_valid  <= 1'b0;
            rsp_err    <= 1'b0;
            hit_ram_q  <= 1'b0;
            hit_tmr_q  <= 1'b0;
            hit_plic_q <= 1'b0;
            we_q       <= 1'b0;
            dbl_q      <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        hit_ram_q  <= dec_ram && !bad_req;
                        hit_tmr_q  <= dec_tmr && !bad_req;
                        hit_plic_q <= dec_plic && !bad_req;
                        we_q       <= req_write;
                        dbl_q      <= dec_ram && !bad_req && req_ls == LS_D;
                        rsp_err    <= bad_req;
                        // errors skip the peripheral
                        state      <= bad_req ? RESP : BEAT0;
                    end
                end
                BEAT0: state <= dbl_q ? BEAT1 : RESP;
                BEAT1: state <= RESP;
                RESP: begin
                    if (!rsp_valid) begin
                        rsp_valid <= 1'b1;
                    end else if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            addr_q  <= req_addr;
            ls_q    <= req_ls;
            wdata_q <= req_wdata;
        end
        // low word of a doubleword arrives during BEAT1
        if (state == BEAT1) begin
            rsp_rdata <= {32'b0, ram.rdata[31:0]};
        end
        if (state == RESP && !rsp_valid) begin
            if (rsp_err || we_q) begin
                rsp_rdata <= '0;
            end else if (dbl_q) begin
                rsp_rdata[63:32] <= ram.rdata[31:0];
            end else begin
                rsp_rdata <= beat_rdata;
            end
        end
    end

    // second beat goes to the next word
    assign beat_addr  = (state == BEAT1) ? addr_q + 32'd4 : addr_q;
    assign beat_wdata = !dbl_q ? wdata_q
                      : (state == BEAT1) ? {32'b0, wdata_q[63:32]} : {32'b0, wdata_q[31:0]};

    always_comb begin
        beat_rdata = '0;
        if (hit_ram_q) beat_rdata = ram.rdata;
        if (hit_tmr_q) beat_rdata = tmr.rdata;
        if (hit_plic_q) beat_rdata = plic.rdata;
    end

    assign ram.sel   = hit_ram_q && (state == BEAT0 || state == BEAT1);
    assign ram.we    = we_q;
    assign ram.addr  = beat_addr;
    assign ram.ls    = ls_q;
    assign ram.wdata = beat_wdata;

    assign tmr.sel   = hit_tmr_q && state == BEAT0;
    assign tmr.we    = we_q;
    assign tmr.addr  = beat_addr;
    assign tmr.ls    = ls_q;
    assign tmr.wdata = beat_wdata;

    assign plic.sel   = hit_plic_q && state == BEAT0;
    assign plic.we    = we_q;
    assign plic.addr  = beat_addr;
    assign plic.ls    = ls_q;
    assign plic.wdata = beat_wdata;

endmodule

// File: design/machine_timer.sv
`timescale 1ns/1ps
`include "soc_bus_defines.svh"

module machine_timer import soc_bus_pkg::*; (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    periph_if.slave  bus,
    output logic     timer_irq
);

    bus_data_t mtime;
    bus_data_t mtimecmp;
    logic      cmp_wr;

    // full 64-bit write, mtime itself is read only here
    assign cmp_wr = bus.sel && bus.we && bus.addr == `MTIMECMP_ADDR;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime     <= '0;
            mtimecmp  <= `MTIMECMP_RESET;
            timer_irq <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (cmp_wr) begin
                mtimecmp <= bus.wdata;
            end
            // registered compare
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus.sel && !bus.we) begin
            bus.rdata <= (bus.addr == `MTIME_ADDR) ? mtime : mtimecmp;
        end
    end

endmodule

// File: design/data_ram.sv
`timescale 1ns/1ps
`include "soc_bus_defines.svh"

module data_ram import soc_bus_pkg::*; (
    input  logic    CLOCK_50,
    periph_if.slave bus
);

    word_t      mem [`RAM_WORDS];
    ram_index_t idx;
    logic [3:0] lane_en;
    word_t      lane_data;
    word_t      rd_word;
    ls_type_e   rd_ls;
    logic [1:0] rd_off;
    word_t      rd_shift;

    // base is 4 KB aligned, so the low address bits index directly
    assign idx = bus.addr[$bits(ram_index_t)+1:2];

    // byte lanes for stores
    always_comb begin
        case (bus.ls[1:0])
            2'b00: begin
                lane_en   = 4'b0001 << bus.addr[1:0];
                lane_data = {4{bus.wdata[7:0]}};
            end
            2'b01: begin
                // halves sit on lane 0 or lane 2
                lane_en   = bus.addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{bus.wdata[15:0]}};
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = bus.wdata[31:0];
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus.sel) begin
            if (bus.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (lane_en[i]) begin
                        mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
                    end
                end
            end else begin
                rd_word <= mem[idx];
                rd_ls   <= bus.ls;
                rd_off  <= bus.addr[1:0];
            end
        end
    end

    assign rd_shift = rd_word >> {rd_off, 3'b000};

    // load extension, a doubleword beat gets the plain word
    always_comb begin
        case (rd_ls)
            LS_B:    bus.rdata = {{56{rd_shift[7]}}, rd_shift[7:0]};
            LS_H:    bus.rdata = {{48{rd_shift[15]}}, rd_shift[15:0]};
            LS_W:    bus.rdata = {{32{rd_shift[31]}}, rd_shift};
            LS_BU:   bus.rdata = {56'b0, rd_shift[7:0]};
            LS_HU:   bus.rdata = {48'b0, rd_shift[15:0]};
            default: bus.rdata = {32'b0, rd_shift};
        endcase
    end

endmodule

// File: design/plic_lite.sv
`timescale 1ns/1ps
`include "soc_bus_defines.svh"

module plic_lite import soc_bus_pkg::*; (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    periph_if.slave bus,
    input  logic    irq_src,
    output logic    meip,
    output logic    seip
);

    irq_prio_t   prio [`PLIC_NUM_IDS];
    logic [31:0] pending;
    logic [31:0] enable [2];
    irq_prio_t   threshold [2];
    logic        irq_s;
    logic        irq_d;
    logic [1:0]  claimable;
    logic [2:0]  prio_id;
    logic        hit_prio;
    logic        hit_pend;
    logic [1:0]  hit_en;
    logic [1:0]  hit_thr;
    logic [1:0]  hit_claim;
    logic        rd;
    logic        wr;
    logic        claim_clr;
    bus_data_t   rd_val;

    assign rd = bus.sel && !bus.we;
    assign wr = bus.sel && bus.we;

    assign hit_prio = bus.addr >= `PLIC_BASE && bus.addr < `PLIC_BASE + 4 * `PLIC_NUM_IDS;
    assign hit_pend = bus.addr == `PLIC_PENDING;
    // id is the word offset from the base
    assign prio_id  = bus.addr[4:2];

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            hit_en[c]    = bus.addr == `PLIC_ENABLE + 32'(c) * `PLIC_ENABLE_STRIDE;
            hit_thr[c]   = bus.addr == `PLIC_THRESHOLD + 32'(c) * `PLIC_CTX_STRIDE;
            hit_claim[c] = bus.addr == `PLIC_CLAIM + 32'(c) * `PLIC_CTX_STRIDE;
            // only source 1 exists, threshold does not gate it
            claimable[c] = pending[1] && enable[c][1];
        end
    end

    assign meip      = claimable[0];
    assign seip      = claimable[1];
    assign claim_clr = rd && |(hit_claim & claimable);

    always_comb begin
        rd_val = '0;
        if (hit_prio) rd_val = {61'b0, prio[prio_id]};
        if (hit_pend) rd_val = {32'b0, pending};
        for (int c = 0; c < 2; c++) begin
            if (hit_en[c]) rd_val = {32'b0, enable[c]};
            if (hit_thr[c]) rd_val = {61'b0, threshold[c]};
            if (hit_claim[c]) rd_val = {63'b0, claimable[c]};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < `PLIC_NUM_IDS; i++) begin
                prio[i] <= '0;
            end
            pending      <= '0;
            enable[0]    <= '0;
            enable[1]    <= '0;
            threshold[0] <= '0;
            threshold[1] <= '0;
            irq_s        <= 1'b0;
            irq_d        <= 1'b0;
        end else begin
            irq_s <= irq_src;
            irq_d <= irq_s;
            if (wr) begin
                if (hit_prio) prio[prio_id] <= bus.wdata[2:0];
                for (int c = 0; c < 2; c++) begin
                    if (hit_en[c]) enable[c] <= bus.wdata[31:0];
                    if (hit_thr[c]) threshold[c] <= bus.wdata[2:0];
                end
            end
            if (claim_clr) pending[1] <= 1'b0;
            // a new edge wins over a claim in the same cycle
            if (irq_s && !irq_d) pending[1] <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rd) begin
            bus.rdata <= rd_val;
        end
    end

endmodule

// File: design/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top import soc_bus_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      req_valid,
    output logic      req_ready,
    input  bus_addr_t req_addr,
    input  logic      req_write,
    input  ls_type_e  req_ls,
    input  bus_data_t req_wdata,
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output bus_data_t rsp_rdata,
    output logic      rsp_err,
    input  logic      irq_src,
    output logic      timer_irq,
    output logic      meip,
    output logic      seip
);

    periph_if ram_bus ();
    periph_if tmr_bus ();
    periph_if plic_bus ();

    bus_sequencer u_seq (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .req_write (req_write),
        .req_ls    (req_ls),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .ram       (ram_bus.master),
        .tmr       (tmr_bus.master),
        .plic      (plic_bus.master)
    );

    data_ram u_ram (
        .CLOCK_50 (CLOCK_50),
        .bus      (ram_bus.slave)
    );

    machine_timer u_tmr (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .bus       (tmr_bus.slave),
        .timer_irq (timer_irq)
    );

    plic_lite u_plic (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (plic_bus.slave),
        .irq_src  (irq_src),
        .meip     (meip),
        .seip     (seip)
    );

endmodule

// File: verif/soc_bus_props.sv
`timescale 1ns/1ps
`include "soc_bus_defines.svh"

module soc_bus_props import soc_bus_pkg::*; (
    input logic      CLOCK_50,
    input logic      KEY0,
    input logic      req_valid,
    input logic      req_ready,
    input bus_addr_t req_addr,
    input ls_type_e  req_ls,
    input logic      rsp_valid,
    input logic      rsp_ready,
    input bus_data_t rsp_rdata,
    input logic      rsp_err
);

    int   fail_count = 0;
    logic accept;
    logic dbl_seen;

    assign accept = req_valid && req_ready;

    // RAM doublewords run one beat more
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            dbl_seen <= 1'b0;
        end else if (accept) begin
            dbl_seen <= (req_addr & 32'hFFFF_F000) == `RAM_BASE && req_ls == LS_D;
        end
    end

    a_reset_idle: assert property (@(posedge CLOCK_50) $rose(KEY0) |-> !rsp_valid && req_ready)
        else begin
            fail_count++;
            $error("response pending or request blocked right after reset");
        end

    a_one_in_flight: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        rsp_valid |-> !req_ready)
        else begin
            fail_count++;
            $error("req_ready high while a response is pending");
        end

    a_rsp_hold: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err))
        else begin
            fail_count++;
            $error("response changed while stalled by rsp_ready");
        end

    // accept edge to rsp_valid edge is 2 cycles, one more in sampled terms
    a_single_beat: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(rsp_valid) && !rsp_err && !dbl_seen |-> $past(accept, 3))
        else begin
            fail_count++;
            $error("single-beat response not 2 cycles after acceptance");
        end

endmodule

// File: verif/tb_soc_bus.sv
`timescale 1ns/1ps
`include "soc_bus_defines.svh"

module tb_soc_bus import soc_bus_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int RSP_LIMIT    = 100;
    localparam int SHADOW_BYTES = 256;
    localparam int FILL_WORDS   = SHADOW_BYTES / 4;
    localparam int RAND_STORES  = 120;
    localparam int RAND_LOADS   = 140;
    localparam int DBL_PAIRS    = 24;
    localparam int MISC_REQS    = 40;
    localparam int TOTAL_REQS   = FILL_WORDS + RAND_STORES + RAND_LOADS
                                + 3 * DBL_PAIRS + MISC_REQS;

    logic      CLOCK_50;
    logic      KEY0;
    logic      req_valid;
    logic      req_ready;
    bus_addr_t req_addr;
    logic      req_write;
    ls_type_e  req_ls;
    bus_data_t req_wdata;
    logic      rsp_valid;
    logic      rsp_ready;
    bus_data_t rsp_rdata;
    logic      rsp_err;
    logic      irq_src;
    logic      timer_irq;
    logic      meip;
    logic      seip;

    logic [31:0] lfsr = 32'h988c;
    logic [7:0]  shadow [SHADOW_BYTES];
    int          errors = 0;

    soc_bus_top DUT (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .req_write (req_write),
        .req_ls    (req_ls),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .irq_src   (irq_src),
        .timer_irq (timer_irq),
        .meip      (meip),
        .seip      (seip)
    );

    bind soc_bus_top soc_bus_props u_props (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .req_ls    (req_ls),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err)
    );

    always #20 CLOCK_50 = ~CLOCK_50;

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // low two bits of the code give log2 of the size
    function automatic int access_bytes(input ls_type_e ls);
        return 1 << ls[1:0];
    endfunction

    // little-endian load from the shadow bytes
    function automatic bus_data_t load_expect(input int off, input ls_type_e ls);
        bus_data_t v;
        int        n;
        n = access_bytes(ls);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = shadow[off + i];
        end
        if (ls inside {LS_B, LS_H, LS_W} && v[8*n-1]) begin
            for (int i = 8 * n; i < 64; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic check_value(input string name, input bus_data_t got, input bus_data_t exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // one request and its response, entered and left 2 ns after an edge
    task automatic bus_access(input bus_addr_t addr, input logic write, input ls_type_e ls,
                              input bus_data_t wdata, output bus_data_t rdata,
                              output logic err);
        int   n;
        logic done;
        rdata     = 'x;
        err       = 1'bx;
        req_valid = 1'b1;
        req_addr  = addr;
        req_write = write;
        req_ls    = ls;
        req_wdata = wdata;
        n = 0;
        while (!req_ready && n < RSP_LIMIT) begin
            @(posedge CLOCK_50);
            #2;
            n++;
        end
        @(posedge CLOCK_50);
        #2;
        req_valid = 1'b0;
        done = 1'b0;
        n = 0;
        while (!done && n < RSP_LIMIT) begin
            // hold off the response about one cycle in four
            rsp_ready = (rand_bits(2) != 0);
            if (rsp_valid && rsp_ready) begin
                rdata = rsp_rdata;
                err   = rsp_err;
                done  = 1'b1;
            end
            @(posedge CLOCK_50);
            #2;
            n++;
        end
        rsp_ready = 1'b0;
        if (!done) begin
            errors++;
            $display("no response for address %h within %0d cycles", addr, RSP_LIMIT);
        end
    endtask

    task automatic checked_access(input bus_addr_t addr, input logic write,
                                  input ls_type_e ls, input bus_data_t wdata,
                                  output bus_data_t rdata);
        logic err;
        bus_access(addr, write, ls, wdata, rdata, err);
        check_bit("rsp_err", err, 1'b0);
    endtask

    task automatic expect_error(input bus_addr_t addr, input logic write, input ls_type_e ls);
        bus_data_t rd;
        logic      err;
        bus_access(addr, write, ls, 64'h0123_4567_89ab_cdef, rd, err);
        check_bit("rsp_err", err, 1'b1);
        check_value("rsp_rdata", rd, '0);
    endtask

    task automatic ram_store(input int off, input ls_type_e ls, input bus_data_t wd);
        bus_data_t rd;
        checked_access(`RAM_BASE + off, 1'b1, ls, wd, rd);
        for (int i = 0; i < access_bytes(ls); i++) begin
            shadow[off + i] = wd[8*i +: 8];
        end
    endtask

    task automatic ram_load(input int off, input ls_type_e ls);
        bus_data_t rd;
        checked_access(`RAM_BASE + off, 1'b0, ls, '0, rd);
        check_value("rsp_rdata", rd, load_expect(off, ls));
    endtask

    initial begin
        repeat (RESET_CYCLES + 200 * TOTAL_REQS) @(posedge CLOCK_50);
        $display("watchdog expired, run did not complete in %0d cycles",
                 RESET_CYCLES + 200 * TOTAL_REQS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        bus_data_t   rd;
        bus_data_t   wd;
        bus_data_t   t0;
        bus_data_t   t1;
        logic [31:0] r;
        ls_type_e    ls;
        int          off;
        int          n;

        CLOCK_50  = 1'b0;
        KEY0      = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_write = 1'b0;
        req_ls    = LS_W;
        req_wdata = '0;
        rsp_ready = 1'b0;
        irq_src   = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
        @(posedge CLOCK_50);
        #2;

        // known contents for the shadowed region first
        for (int k = 0; k < FILL_WORDS; k++) begin
            wd = {32'b0, rand_bits(32)};
            ram_store(4 * k, LS_W, wd);
        end
        for (int k = 0; k < RAND_STORES; k++) begin
            r   = rand_bits(2);
            ls  = ls_type_e'({1'b0, r[1:0]});
            r   = rand_bits(8);
            off = int'(r[7:0]) & ~(access_bytes(ls) - 1);
            wd[63:32] = rand_bits(32);
            wd[31:0]  = rand_bits(32);
            ram_store(off, ls, wd);
        end
        // cycle through all seven load codes
        for (int k = 0; k < RAND_LOADS; k++) begin
            ls  = ls_type_e'(3'(k % 7));
            r   = rand_bits(8);
            off = int'(r[7:0]) & ~(access_bytes(ls) - 1);
            ram_load(off, ls);
        end

        for (int k = 0; k < DBL_PAIRS; k++) begin
            r   = rand_bits(5);
            off = 8 * int'(r[4:0]);
            wd[63:32] = rand_bits(32);
            wd[31:0]  = rand_bits(32);
            ram_store(off, LS_D, wd);
            ram_load(off, LS_D);
            // low half lands at the lower address
            checked_access(`RAM_BASE + off, 1'b0, LS_WU, '0, rd);
            check_value("rsp_rdata", rd, {32'b0, wd[31:0]});
        end

        // machine timer
        checked_access(`MTIME_ADDR, 1'b0, LS_D, '0, t0);
        checked_access(`MTIME_ADDR, 1'b0, LS_D, '0, t1);
        assert (t1 > t0) else begin
            errors++;
            $display("MISMATCH at %0t: mtime got %h expected above %h", $time, t1, t0);
        end
        checked_access(`MTIMECMP_ADDR, 1'b1, LS_D, t1 + 64'd50, rd);
        n = 0;
        while (!timer_irq && n < 60) begin
            @(posedge CLOCK_50);
            #2;
            n++;
        end
        check_bit("timer_irq", timer_irq, 1'b1);
        checked_access(`MTIMECMP_ADDR, 1'b1, LS_D, '1, rd);
        repeat (2) @(posedge CLOCK_50);
        #2;
        check_bit("timer_irq", timer_irq, 1'b0);
        checked_access(`MTIMECMP_ADDR, 1'b0, LS_D, '0, rd);
        check_value("mtimecmp", rd, '1);

        // interrupt controller, source 1 enabled for context 0 only
        checked_access(`PLIC_ENABLE, 1'b1, LS_W, 64'h2, rd);
        checked_access(`PLIC_ENABLE + `PLIC_ENABLE_STRIDE, 1'b1, LS_W, '0, rd);
        irq_src = 1'b1;
        repeat (3) @(posedge CLOCK_50);
        #2;
        irq_src = 1'b0;
        n = 0;
        while (!meip && n < 10) begin
            @(posedge CLOCK_50);
            #2;
            n++;
        end
        check_bit("meip", meip, 1'b1);
        check_bit("seip", seip, 1'b0);
        checked_access(`PLIC_CLAIM, 1'b0, LS_W, '0, rd);
        check_value("claim", rd, 64'd1);
        check_bit("meip", meip, 1'b0);
        checked_access(`PLIC_CLAIM, 1'b0, LS_W, '0, rd);
        check_value("claim", rd, 64'd0);
        for (int id = 1; id < `PLIC_NUM_IDS; id++) begin
            r = rand_bits(3);
            checked_access(`PLIC_BASE + 32'(4 * id), 1'b1, LS_W, {32'b0, r}, rd);
            checked_access(`PLIC_BASE + 32'(4 * id), 1'b0, LS_W, '0, rd);
            check_value("priority", rd, {61'b0, r[2:0]});
        end
        for (int c = 0; c < 2; c++) begin
            r = rand_bits(3);
            checked_access(`PLIC_THRESHOLD + 32'(c) * `PLIC_CTX_STRIDE, 1'b1, LS_W,
                           {32'b0, r}, rd);
            checked_access(`PLIC_THRESHOLD + 32'(c) * `PLIC_CTX_STRIDE, 1'b0, LS_W, '0, rd);
            check_value("threshold", rd, {61'b0, r[2:0]});
        end

        // unmapped and misaligned requests
        expect_error(32'h1000_0000, 1'b0, LS_W);
        expect_error(`RAM_BASE + `RAM_BYTES, 1'b0, LS_W);
        expect_error(`RAM_BASE + 32'd1, 1'b0, LS_H);
        expect_error(`RAM_BASE + 32'd2, 1'b0, LS_W);
        expect_error(`RAM_BASE + 32'd4, 1'b0, LS_D);
        expect_error(`RAM_BASE + 32'd3, 1'b1, LS_H);
        ram_load(0, LS_W);
        ram_load(2, LS_HU);

        $display("errors: %0d check failures, %0d assertion failures",
                 errors, DUT.u_props.fail_count);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+design
design/soc_bus_pkg.sv
design/periph_if.sv
design/bus_sequencer.sv
design/machine_timer.sv
design/data_ram.sv
design/plic_lite.sv
design/soc_bus_top.sv
verif/soc_bus_props.sv
verif/tb_soc_bus.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_soc_bus
FILELIST  := files.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
RUNFLAGS  := +verilator+error+limit+1000
SIM       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(SIM) $(RUNFLAGS) | tee /dev/stderr | grep -F '>>> PASS' > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
